//--- list.f
+incdir+.
spi_mode_pkg.sv
spi_frame_pkg.sv
spi_link_ifs.sv
spi_sck_gen.sv
spi_delay_timer.sv
spi_shifter.sv
spi_frame_ctrl.sv
spi_master_top.sv
spi_master_sva.sv
tb_spi_master.sv

//--- Bender.yml
package:
  name: spi_master

export_include_dirs:
  - .

sources:
  - spi_mode_pkg.sv
  - spi_frame_pkg.sv
  - spi_link_ifs.sv
  - spi_sck_gen.sv
  - spi_delay_timer.sv
  - spi_shifter.sv
  - spi_frame_ctrl.sv
  - spi_master_top.sv
  - target: test
    files:
      - spi_master_sva.sv
      - tb_spi_master.sv

//--- tb_spi_master.sv
`include "spi_defs.svh"

module tb_spi_master;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 20000; // GCLK cycles per wait

    logic                   GCLK = 1'b0;
    logic                   NRST;
    logic                   start_i;
    logic                   miso_i = 1'b0;
    logic [1:0]             spi_mode_i, sck_speed_i, word_len_i;
    logic [`SPI_DLY_W-1:0]  ifg_i, cs_sck_i, sck_cs_i;
    logic [`SPI_DATA_W-1:0] mosi_data_i, miso_data_o;
    logic                   busy_o, mosi_o, sclk_o, cs_o;

    integer                 seed = 32'hc2b0abac;
    int                     errors = 0;
    int                     cyc = 0;
    logic [`SPI_DATA_W-1:0] slv_word = '0;
    logic [`SPI_DATA_W-1:0] rec;         // mosi bits seen by the slave
    int                     slv_bits = 32;
    int                     idx, edges, last_tgl, min_gap, max_gap;
    int                     fall_cyc, first_dly, ifg_seen;
    int                     rise_cyc = 0;
    int                     cs_falls = 0;
    logic                   prev_sclk, prev_cs = 1'b1;

    spi_master_top dut (.*);

    bind spi_master_top spi_master_sva u_sva (
        .GCLK(GCLK), .NRST(NRST), .cs_o(cs_o), .busy_o(busy_o), .sclk_o(sclk_o),
        .spi_mode_i(spi_mode_i), .miso_data_o(miso_data_o)
    );

    always #4 GCLK = ~GCLK;

    function automatic int bits_for(input logic [1:0] code);
        return 32 >> code;  // 32, 16, 8, 4
    endfunction

    function automatic int half_for(input logic [1:0] code);
        return 64 >> code;  // 64, 32, 16, 8 GCLK cycles
    endfunction

    ////////////////////
    // spi slave model
    ////////////////////

    // runs on the falling edge one cycle after any sck toggle
    always @(negedge GCLK) begin
        cyc = cyc + 1;
        if (!cs_o && prev_cs) begin
            cs_falls++;
            fall_cyc = cyc;
            ifg_seen = cyc - rise_cyc;
            edges    = 0;
            idx      = 0;
            rec      = '0;
            min_gap  = WAIT_LIMIT;
            max_gap  = 0;
            if (!spi_mode_i[0]) begin  // cpha 0 puts the msb out before the first edge
                miso_i = slv_word[slv_bits-1];
                idx    = 1;
            end
        end
        if (cs_o && !prev_cs)
            rise_cyc = cyc;
        if (!cs_o && sclk_o !== prev_sclk) begin
            if (edges == 0)
                first_dly = cyc - fall_cyc;
            else if (cyc - last_tgl < min_gap)
                min_gap = cyc - last_tgl;
            if (edges != 0 && cyc - last_tgl > max_gap)
                max_gap = cyc - last_tgl;
            last_tgl = cyc;
            edges++;
            if ((sclk_o != spi_mode_i[1]) ^ spi_mode_i[0]) begin
                rec = {rec[`SPI_DATA_W-2:0], mosi_o};       // sample edge
            end else if (idx < slv_bits) begin
                miso_i = slv_word[slv_bits-1-idx];          // change edge
                idx++;
            end
        end
        prev_cs   = cs_o;
        prev_sclk = sclk_o;
    end

    task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy_o !== level && n < WAIT_LIMIT) begin
            @(negedge GCLK);
            n++;
        end
        if (busy_o !== level) begin
            $display("timeout: busy_o never went to %0b", level);
            $display("Something failed");
            $finish;
        end
    endtask

    // one frame with random data checked end to end
    task automatic run_frame(input logic [1:0] mode, input logic [1:0] rate,
                             input logic [1:0] wlen, input logic [7:0] lead,
                             input logic [7:0] gap, input bit poke);
        logic [`SPI_DATA_W-1:0] mask;
        int                     nbits;
        int                     falls0;
        nbits       = bits_for(wlen);
        mask        = {`SPI_DATA_W{1'b1}} >> (`SPI_DATA_W - nbits);
        spi_mode_i  = mode;
        sck_speed_i = rate;
        word_len_i  = wlen;
        cs_sck_i    = lead;
        sck_cs_i    = lead;
        ifg_i       = gap;
        mosi_data_i = $random(seed);
        slv_word    = $random(seed) & mask;
        slv_bits    = nbits;
        falls0      = cs_falls;
        repeat (2) @(negedge GCLK);
        if (sclk_o !== mode[1]) mismatch("sclk_o idle before frame", sclk_o, mode[1]);
        start_i = 1'b1;
        @(negedge GCLK);
        start_i = 1'b0;
        wait_busy(1'b1);
        if (poke) begin  // a start edge in mid frame must be dropped
            repeat (5) @(negedge GCLK);
            start_i = 1'b1;
            @(negedge GCLK);
            start_i = 1'b0;
        end
        wait_busy(1'b0);
        if (rec !== (mosi_data_i & mask)) mismatch("word seen by slave", rec, mosi_data_i & mask);
        if (miso_data_o !== slv_word) mismatch("miso_data_o", miso_data_o, slv_word);
        if (sclk_o !== mode[1]) mismatch("sclk_o idle after frame", sclk_o, mode[1]);
        if (edges != 2 * nbits) mismatch("sck edge count", edges, 2 * nbits);
        if (min_gap != half_for(rate)) mismatch("shortest sck half period", min_gap, half_for(rate));
        if (max_gap != half_for(rate)) mismatch("longest sck half period", max_gap, half_for(rate));
        if (first_dly < lead || first_dly > lead + 2)
            mismatch("cs to first sck (min)", first_dly, lead);
        if (ifg_seen < gap) mismatch("interframe gap (min)", ifg_seen, gap);
        repeat (gap + 4) @(negedge GCLK);
        if (cs_falls != falls0 + 1) mismatch("frames launched", cs_falls - falls0, 1);
        if (busy_o !== 1'b0) mismatch("busy_o after frame", busy_o, 1'b0);
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic after_reset;
        @(negedge GCLK);
        if (cs_o !== 1'b1) mismatch("cs_o after reset", cs_o, 1'b1);
        if (busy_o !== 1'b0) mismatch("busy_o after reset", busy_o, 1'b0);
        if (miso_data_o !== '0) mismatch("miso_data_o after reset", miso_data_o, 0);
        if (sclk_o !== spi_mode_i[1]) mismatch("sclk_o after reset", sclk_o, spi_mode_i[1]);
    endtask

    task automatic mode0_word32;
        run_frame(2'd0, 2'd2, 2'd0, 8'd2, 8'd4, 1'b0);
    endtask

    task automatic all_modes_byte;
        for (int m = 0; m < 4; m++)
            run_frame(2'(m), 2'd3, 2'd2, 8'd1, 8'd3, 1'b0);
    endtask

    task automatic short_words;
        run_frame(2'd1, 2'd3, 2'd1, 8'd2, 8'd4, 1'b0); // 16 bits
        run_frame(2'd3, 2'd3, 2'd3, 8'd2, 8'd4, 1'b0); // 4 bits
    endtask

    task automatic sck_rates;
        for (int r = 0; r < 4; r++)
            run_frame(2'd2, 2'(r), 2'd3, 8'd1, 8'd2, 1'b0);
    endtask

    task automatic delays_and_start;
        run_frame(2'd1, 2'd3, 2'd2, 8'd3, 8'd4, 1'b1);
        run_frame(2'd1, 2'd3, 2'd2, 8'd1, 8'd40, 1'b0); // gap longer than the idle time
    endtask

    initial begin
        NRST        = 1'b0;
        start_i     = 1'b0;
        spi_mode_i  = 2'd2;  // cpol 1 makes the reset idle level visible
        sck_speed_i = 2'd0;
        word_len_i  = 2'd0;
        ifg_i       = 8'd4;
        cs_sck_i    = 8'd1;
        sck_cs_i    = 8'd1;
        mosi_data_i = '0;
        repeat (3) @(negedge GCLK);
        NRST = 1'b1;
        after_reset;
        mode0_word32;
        all_modes_byte;
        short_words;
        sck_rates;
        delays_and_start;
        $display("frames: %0d, errors: %0d", cs_falls, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- spi_master_sva.sv
`include "spi_defs.svh"

module spi_master_sva (
    input logic                   GCLK,
    input logic                   NRST,
    input logic                   cs_o,
    input logic                   busy_o,
    input logic                   sclk_o,
    input logic [1:0]             spi_mode_i,
    input logic [`SPI_DATA_W-1:0] miso_data_o
);
    timeunit 1ns;
    timeprecision 1ps;

    busy_is_not_cs: assert property (@(posedge GCLK) disable iff (!NRST) busy_o == !cs_o)
        else $error("busy_o and cs_o disagree");

    // with cs high sck only ever sits at the cpol of the mode
    sclk_quiet: assert property (@(posedge GCLK) disable iff (!NRST)
        cs_o |-> sclk_o == $past(spi_mode_i[1]))
        else $error("sclk_o moved while cs_o was high");

    rx_on_frame_end: assert property (@(posedge GCLK) disable iff (!NRST)
        $changed(miso_data_o) |-> $fell(busy_o))
        else $error("miso_data_o changed outside a frame end");

endmodule

//--- spi_master_top.sv
`include "spi_defs.svh"

module spi_master_top (
    input  logic                   GCLK,
    input  logic                   NRST,
    input  logic                   start_i,
    input  logic [1:0]             spi_mode_i,
    input  logic [1:0]             sck_speed_i,
    input  logic [1:0]             word_len_i,
    input  logic [`SPI_DLY_W-1:0]  ifg_i,
    input  logic [`SPI_DLY_W-1:0]  cs_sck_i,
    input  logic [`SPI_DLY_W-1:0]  sck_cs_i,
    input  logic [`SPI_DATA_W-1:0] mosi_data_i,
    input  logic                   miso_i,
    output logic                   busy_o,
    output logic [`SPI_DATA_W-1:0] miso_data_o,
    output logic                   mosi_o,
    output logic                   sclk_o,
    output logic                   cs_o
);

    logic load;
    logic publish;

    spi_sck_if   sck_if ();
    spi_delay_if dly_if ();

    assign sclk_o = sck_if.sck;

    spi_frame_ctrl u_ctrl (
        .GCLK(GCLK), .NRST(NRST), .start_i(start_i),
        .spi_mode_i(spi_mode_i), .sck_speed_i(sck_speed_i), .word_len_i(word_len_i),
        .busy_o(busy_o), .cs_o(cs_o), .load_o(load), .publish_o(publish),
        .sck(sck_if.ctrl), .dly(dly_if.ctrl)
    );

    spi_sck_gen u_sck (.GCLK(GCLK), .NRST(NRST), .sck(sck_if.gen));

    spi_delay_timer u_dly (
        .GCLK(GCLK), .NRST(NRST), .ifg_i(ifg_i), .cs_sck_i(cs_sck_i),
        .sck_cs_i(sck_cs_i), .dly(dly_if.timer)
    );

    spi_shifter u_shift (
        .GCLK(GCLK), .NRST(NRST), .load_i(load), .publish_i(publish),
        .tx_data_i(mosi_data_i), .word_len_i(word_len_i), .miso_i(miso_i),
        .mosi_o(mosi_o), .rx_data_o(miso_data_o), .stb(sck_if.strobe)
    );

endmodule

//--- spi_frame_ctrl.sv
`include "spi_defs.svh"

module spi_frame_ctrl (
    input  logic       GCLK,
    input  logic       NRST,
    input  logic       start_i,
    input  logic [1:0] spi_mode_i,
    input  logic [1:0] sck_speed_i,
    input  logic [1:0] word_len_i,
    output logic       busy_o,
    output logic       cs_o,
    output logic       load_o,
    output logic       publish_o,
    spi_sck_if.ctrl    sck,
    spi_delay_if.ctrl  dly
);

    logic                    start_q;
    logic                    start_edge;
    logic [2:0]              state_q;
    logic                    cs_q;
    logic                    run_q;
    spi_mode_pkg::spi_mode_u mode_q;
    logic [1:0]              rate_q;
    logic [1:0]              wlen_q;

    assign start_edge = start_i & ~start_q;
    assign load_o     = (state_q == `SPI_ST_IDLE) & start_edge; // edges while busy are lost
    assign publish_o  = (state_q == `SPI_ST_TRAIL) & dly.trail_done;

    assign cs_o         = cs_q;
    assign busy_o       = ~cs_q;
    assign dly.cs_low   = ~cs_q;
    assign dly.trail_go = (state_q == `SPI_ST_XFER) & sck.done;

    // idle sck follows the live mode input, a frame uses the latched one
    assign sck.mode = (state_q == `SPI_ST_IDLE) ? spi_mode_pkg::spi_mode_u'(spi_mode_i) : mode_q;
    assign sck.run  = run_q;
    assign sck.rate = rate_q;
    assign sck.wlen = wlen_q;

    always_ff @(posedge GCLK) begin
        if (load_o) begin
            mode_q.num <= spi_mode_i;
            rate_q     <= sck_speed_i;
            wlen_q     <= word_len_i;
        end
    end

    ////////////////////
    // frame fsm
    ////////////////////

    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            start_q <= 1'b0;
            state_q <= `SPI_ST_IDLE;
            cs_q    <= 1'b1;
            run_q   <= 1'b0;
        end else begin
            start_q <= start_i;
            case (state_q)
                `SPI_ST_IDLE:  if (start_edge) state_q <= `SPI_ST_GAP;
                `SPI_ST_GAP: if (dly.gap_ok) begin
                    cs_q    <= 1'b0;             // busy rises with it
                    state_q <= `SPI_ST_LEAD;
                end
                `SPI_ST_LEAD: if (dly.lead_done) begin
                    run_q   <= 1'b1;
                    state_q <= `SPI_ST_XFER;
                end
                `SPI_ST_XFER: if (sck.done) begin
                    run_q   <= 1'b0;
                    state_q <= `SPI_ST_TRAIL;
                end
                `SPI_ST_TRAIL: if (dly.trail_done) begin
                    cs_q    <= 1'b1;             // same edge as the rx publish
                    state_q <= `SPI_ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- spi_shifter.sv
`include "spi_defs.svh"

module spi_shifter (
    input  logic                   GCLK,
    input  logic                   NRST,
    input  logic                   load_i,
    input  logic                   publish_i,
    input  logic [`SPI_DATA_W-1:0] tx_data_i,
    input  logic [1:0]             word_len_i,
    input  logic                   miso_i,
    output logic                   mosi_o,
    output logic [`SPI_DATA_W-1:0] rx_data_o,
    spi_sck_if.strobe              stb
);

    logic [`SPI_DATA_W-1:0] tx_q;
    logic [`SPI_DATA_W-1:0] rx_q;

    assign mosi_o = tx_q[`SPI_DATA_W-1];

    // transmit side, word moved up so its first bit is the msb
    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            tx_q <= '0;                     // keeps mosi low out of reset
        end else if (load_i) begin
            tx_q <= tx_data_i << (`SPI_DATA_W - spi_frame_pkg::word_bits(word_len_i));
        end else if (stb.shift_stb) begin
            tx_q <= {tx_q[`SPI_DATA_W-2:0], 1'b0};
        end
    end

    // receive side fills from the lsb, so short words end up right-justified
    always_ff @(posedge GCLK) begin
        if (load_i) begin
            rx_q <= '0;
        end else if (stb.sample_stb) begin
            rx_q <= {rx_q[`SPI_DATA_W-2:0], miso_i};
        end
    end

    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            rx_data_o <= '0;
        end else if (publish_i) begin
            rx_data_o <= rx_q;
        end
    end

endmodule

//--- spi_delay_timer.sv
`include "spi_defs.svh"

module spi_delay_timer (
    input  logic                  GCLK,
    input  logic                  NRST,
    input  logic [`SPI_DLY_W-1:0] ifg_i,
    input  logic [`SPI_DLY_W-1:0] cs_sck_i,
    input  logic [`SPI_DLY_W-1:0] sck_cs_i,
    spi_delay_if.timer            dly
);

    logic [`SPI_DLY_W-1:0] gap_cnt;
    logic [`SPI_DLY_W-1:0] dly_cnt;
    logic [`SPI_DLY_W-1:0] dly_lim;
    logic                  cs_low_q;
    logic                  dly_busy;   // lead or trail delay running
    logic                  trail_sel;  // 0: lead, 1: trail
    logic                  dly_hit;

    ////////////////////
    // interframe gap
    ////////////////////

    // counts while cs is high, saturates at the gap
    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            gap_cnt <= '0;
        end else if (dly.cs_low) begin
            gap_cnt <= '0;
        end else if (gap_cnt < ifg_i) begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    assign dly.gap_ok = (gap_cnt >= ifg_i);

    ////////////////////
    // lead / trail
    ////////////////////

    assign dly_lim        = trail_sel ? sck_cs_i : cs_sck_i;
    assign dly_hit        = dly_busy & (dly_cnt >= dly_lim); // a zero limit acts as 1
    assign dly.lead_done  = dly_hit & ~trail_sel;
    assign dly.trail_done = dly_hit & trail_sel;

    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            cs_low_q  <= 1'b0;
            dly_busy  <= 1'b0;
            trail_sel <= 1'b0;
            dly_cnt   <= '0;
        end else begin
            cs_low_q <= dly.cs_low;
            if (dly.cs_low & ~cs_low_q) begin
                dly_busy  <= 1'b1;
                trail_sel <= 1'b0;
                dly_cnt   <= `SPI_DLY_W'(1);
            end else if (dly.trail_go) begin
                dly_busy  <= 1'b1;
                trail_sel <= 1'b1;
                dly_cnt   <= `SPI_DLY_W'(1);
            end else if (dly_hit) begin
                dly_busy  <= 1'b0;
            end else if (dly_busy) begin
                dly_cnt   <= dly_cnt + 1'b1;
            end
        end
    end

endmodule

//--- spi_sck_gen.sv
`include "spi_defs.svh"

module spi_sck_gen (
    input  logic   GCLK,
    input  logic   NRST,
    spi_sck_if.gen sck
);

    logic [`SPI_DIV_W-1:0]  half_cyc;
    logic [`SPI_EDGE_W-1:0] edge_tot;
    logic [`SPI_DIV_W-1:0]  div_cnt;
    logic [`SPI_EDGE_W-1:0] edge_cnt;  // edges already produced
    logic                   sck_q;
    logic                   toggle;
    logic                   lead_edge;
    logic                   first_edge;
    logic                   last_edge;

    assign half_cyc = spi_frame_pkg::half_period(sck.rate);
    assign edge_tot = spi_frame_pkg::word_bits(sck.wlen) << 1; // two edges per bit

    assign toggle     = sck.run & (edge_cnt != edge_tot) & (div_cnt == half_cyc - 1'b1);
    assign lead_edge  = ~edge_cnt[0];  // even edges leave the idle level
    assign first_edge = (edge_cnt == '0);
    assign last_edge  = (edge_cnt == edge_tot - 1'b1);

    ////////////////////
    // strobes
    ////////////////////

    // cpha 0 samples on leading edges, cpha 1 on trailing ones.
    // the msb sits on mosi from the load, so the very first edge never
    // shifts, and nothing is left to send after the very last edge
    assign sck.sample_stb = toggle & (lead_edge ^ sck.mode.pol_pha.cpha);
    assign sck.shift_stb  = toggle & ~(lead_edge ^ sck.mode.pol_pha.cpha)
                          & ~first_edge & ~last_edge;

    assign sck.sck = sck_q;

    ////////////////////
    // divider
    ////////////////////

    always_ff @(posedge GCLK) begin
        if (!NRST) begin
            div_cnt  <= '0;
            edge_cnt <= '0;
            sck_q    <= sck.mode.pol_pha.cpol;
            sck.done <= 1'b0;
        end else begin
            sck.done <= toggle & last_edge;
            if (!sck.run) begin
                div_cnt  <= half_cyc - 1'b1; // first toggle right after run rises
                edge_cnt <= '0;
                sck_q    <= sck.mode.pol_pha.cpol;
            end else if (toggle) begin
                div_cnt  <= '0;
                edge_cnt <= edge_cnt + 1'b1;
                sck_q    <= ~sck_q;
            end else if (edge_cnt != edge_tot) begin
                div_cnt  <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- spi_link_ifs.sv
// frame controller <-> sck generator, strobes also go to the shifter
interface spi_sck_if;
    logic                    run;        // high from end of lead delay to after done
    spi_mode_pkg::spi_mode_u mode;
    logic [1:0]              rate;
    logic [1:0]              wlen;
    logic                    sck;
    logic                    sample_stb; // capture miso on this GCLK edge
    logic                    shift_stb;  // advance mosi on this GCLK edge
    logic                    done;       // one cycle after the last edge

    modport ctrl (output run, mode, rate, wlen, input done);
    modport gen (
        input  run, mode, rate, wlen,
        output sck, sample_stb, shift_stb, done
    );
    modport strobe (input sample_stb, shift_stb);
endinterface

// frame controller <-> delay timer
interface spi_delay_if;
    logic cs_low;     // level, follows the chip select
    logic trail_go;   // pulse, starts the sck-to-cs delay
    logic gap_ok;     // level, interframe gap has run out
    logic lead_done;  // pulse
    logic trail_done; // pulse

    modport ctrl (
        output cs_low, trail_go,
        input  gap_ok, lead_done, trail_done
    );
    modport timer (
        input  cs_low, trail_go,
        output gap_ok, lead_done, trail_done
    );
endinterface

//--- spi_frame_pkg.sv
`include "spi_defs.svh"

package spi_frame_pkg;

    // number of data bits in a frame for a word-length code
    function automatic logic [`SPI_EDGE_W-1:0] word_bits(input logic [1:0] code);
        case (code)
            2'd0:    word_bits = `SPI_EDGE_W'(32);
            2'd1:    word_bits = `SPI_EDGE_W'(16);
            2'd2:    word_bits = `SPI_EDGE_W'(8);
            default: word_bits = `SPI_EDGE_W'(4);
        endcase
    endfunction

    // GCLK cycles between two sck toggles
    function automatic logic [`SPI_DIV_W-1:0] half_period(input logic [1:0] code);
        case (code)
            `SPI_RATE_DIV128: half_period = `SPI_DIV_W'(64);
            `SPI_RATE_DIV64:  half_period = `SPI_DIV_W'(32);
            `SPI_RATE_DIV32:  half_period = `SPI_DIV_W'(16);
            default:          half_period = `SPI_DIV_W'(8); // divide by 16
        endcase
    endfunction

endpackage

//--- spi_mode_pkg.sv
package spi_mode_pkg;

    ////////////////////
    // spi mode word
    ////////////////////

    // mode 0: sck idles low,  sample on rising, change on falling
    // mode 1: sck idles low,  change on rising, sample on falling
    // mode 2: sck idles high, sample on falling, change on rising
    // mode 3: sck idles high, change on falling, sample on rising

    typedef union packed {
        logic [1:0] num;      // mode number as given on spi_mode_i
        struct packed {
            logic cpol;       // idle level of sck
            logic cpha;       // 1: sample on trailing edges
        } pol_pha;
    } spi_mode_u;

endpackage

//--- spi_defs.svh
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

`define SPI_DATA_W 32 // parallel word width
`define SPI_DLY_W  8  // ifg, cs-to-sck and sck-to-cs inputs
`define SPI_DIV_W  7  // sck half-period counter, up to 64
`define SPI_EDGE_W 7  // up to 64 sck edges in one frame

// sck rate codes, named by the full-period divide of GCLK
`define SPI_RATE_DIV128 2'd0
`define SPI_RATE_DIV64  2'd1
`define SPI_RATE_DIV32  2'd2
`define SPI_RATE_DIV16  2'd3

`define SPI_ST_IDLE  3'd0
`define SPI_ST_GAP   3'd1 // waiting out the interframe gap, cs still high
`define SPI_ST_LEAD  3'd2
`define SPI_ST_XFER  3'd3
`define SPI_ST_TRAIL 3'd4

`endif
